// File: Bender.yml
package:
  name: robCore

sources:
  - design/robPkg.sv
  - design/robPtrIf.sv
  - design/robPointers.sv
  - design/robRecoveryFsm.sv
  - design/robEntryStore.sv
  - design/archMapTable.sv
  - design/reorderBuffer.sv
  - target: test
    files:
      - testbench/reorderBuffer_chk.sv
      - testbench/reorderBufferTb.sv

// File: design/archMapTable.sv
`timescale 1ns/1ps
`default_nettype none

module archMapTable import robPkg::*; (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic    [superWidth-1:0] retireValid,
  input  wire archRegT [superWidth-1:0] retireDest,
  input  wire physTagT [superWidth-1:0] retireTag,
  input  wire archRegT                  archReadReg,
  output physTagT                       archReadTag
);

  physTagT mapTag [archRegNum];

  // committed mapping of each architectural register
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int r = 0; r < archRegNum; r++) begin
        mapTag[r] <= physTagT'(r);
      end
    end else begin
      // later slot is younger, so its write lands last
      for (int s = 0; s < superWidth; s++) begin
        if (retireValid[s]) begin
          mapTag[retireDest[s]] <= retireTag[s];
        end
      end
    end
  end

  assign archReadTag = mapTag[archReadReg];

endmodule

`default_nettype wire

// File: design/reorderBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer import robPkg::*; (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire logic                     dispatchEn,
  input  wire archRegT [superWidth-1:0] dispatchDest,
  input  wire physTagT [superWidth-1:0] dispatchTag,
  input  wire physTagT [superWidth-1:0] dispatchTold,
  input  wire logic    [superWidth-1:0] dispatchHalt,
  input  wire logic    [superWidth-1:0] completeEn,
  input  wire robIdxT  [superWidth-1:0] completeIdx,
  input  wire logic                     rollbackEn,
  input  wire robIdxT                   rollbackIdx,
  input  wire archRegT                  archReadReg,
  output logic                          robReady,
  output robIdxT       [superWidth-1:0] robIdx,
  output logic         [superWidth-1:0] retireValid,
  output physTagT      [superWidth-1:0] retireTold,
  output logic                          haltOut,
  output physTagT                       archReadTag
);

  logic    freeTwo;
  logic    empty;
  logic    rollbackValid;
  archRegT [superWidth-1:0] retireDest;
  physTagT [superWidth-1:0] retireTag;

  robPtrIf ptrIf ();

  // indices the next dispatch pair takes
  assign robIdx[0] = ptrIf.tail;
  assign robIdx[1] = ptrIf.tailPlusOne;

  robPointers i_robPointers (
    .clock   (clock),
    .reset   (reset),
    .ptrs    (ptrIf.ptr),
    .freeTwo (freeTwo),
    .empty   (empty)
  );

  robRecoveryFsm i_robRecoveryFsm (
    .clock         (clock),
    .reset         (reset),
    .dispatchEn    (dispatchEn),
    .rollbackEn    (rollbackEn),
    .rollbackIdx   (rollbackIdx),
    .rollbackValid (rollbackValid),
    .freeTwo       (freeTwo),
    .empty         (empty),
    .ctl           (ptrIf.ctl),
    .robReady      (robReady)
  );

  robEntryStore i_robEntryStore (
    .clock         (clock),
    .reset         (reset),
    .dispatchDest  (dispatchDest),
    .dispatchTag   (dispatchTag),
    .dispatchTold  (dispatchTold),
    .dispatchHalt  (dispatchHalt),
    .completeEn    (completeEn),
    .completeIdx   (completeIdx),
    .rollbackIdx   (rollbackIdx),
    .store         (ptrIf.store),
    .rollbackValid (rollbackValid),
    .retireValid   (retireValid),
    .retireTold    (retireTold),
    .retireDest    (retireDest),
    .retireTag     (retireTag),
    .haltOut       (haltOut)
  );

  archMapTable i_archMapTable (
    .clock       (clock),
    .reset       (reset),
    .retireValid (retireValid),
    .retireDest  (retireDest),
    .retireTag   (retireTag),
    .archReadReg (archReadReg),
    .archReadTag (archReadTag)
  );

endmodule

`default_nettype wire

// File: design/robEntryStore.sv
`timescale 1ns/1ps
`default_nettype none

module robEntryStore import robPkg::*; (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire archRegT [superWidth-1:0] dispatchDest,
  input  wire physTagT [superWidth-1:0] dispatchTag,
  input  wire physTagT [superWidth-1:0] dispatchTold,
  input  wire logic    [superWidth-1:0] dispatchHalt,
  input  wire logic    [superWidth-1:0] completeEn,
  input  wire robIdxT  [superWidth-1:0] completeIdx,
  input  wire robIdxT                   rollbackIdx,
  robPtrIf.store                        store,
  output logic                          rollbackValid,
  output logic         [superWidth-1:0] retireValid,
  output physTagT      [superWidth-1:0] retireTold,
  output archRegT      [superWidth-1:0] retireDest,
  output physTagT      [superWidth-1:0] retireTag,
  output logic                          haltOut
);

  // control bits
  logic [robDepth-1:0] valid;
  logic [robDepth-1:0] complete;

  // payload
  logic    halt [robDepth];
  archRegT dest [robDepth];
  physTagT tag  [robDepth];
  physTagT told [robDepth];

  robIdxT  slotIdx [superWidth];
  robIdxT  squashStart;
  robIdxT  squashSpan;
  logic [robDepth-1:0] setComplete;
  logic [robDepth-1:0] clearValid;
  logic [robDepth-1:0] writeEntry;

  // slot 0 is the head, slot 1 the entry after it
  assign slotIdx[0] = store.head;
  assign slotIdx[1] = store.headPlusOne;

  assign rollbackValid = valid[rollbackIdx];

  // in-order retirement; slot 1 also held back if the head branch rolls back
  assign retireValid[0] = valid[store.head] && complete[store.head];
  assign retireValid[1] = retireValid[0] && valid[store.headPlusOne]
                          && complete[store.headPlusOne]
                          && !(store.rollbackFire && rollbackIdx == store.head);

  assign store.retireCount = retireValid[1] ? retireCountT'(2) :
                             retireValid[0] ? retireCountT'(1) : retireCountT'(0);

  always_comb begin
    haltOut = 1'b0;
    for (int s = 0; s < superWidth; s++) begin
      retireTold[s] = told[slotIdx[s]];
      retireDest[s] = dest[slotIdx[s]];
      retireTag[s]  = tag[slotIdx[s]];
      haltOut       = haltOut | (retireValid[s] && halt[slotIdx[s]]);
    end
  end

  // squash window runs from rollbackIdx+1 up to, not including, the old tail
  assign squashStart = rollbackIdx + robIdxT'(1);
  assign squashSpan  = store.tail - squashStart;

  always_comb begin
    setComplete = '0;
    clearValid  = '0;
    writeEntry  = '0;
    for (int i = 0; i < robDepth; i++) begin
      for (int s = 0; s < superWidth; s++) begin
        if (completeEn[s] && completeIdx[s] == robIdxT'(i) && valid[i]) begin
          setComplete[i] = 1'b1;
        end
        if (retireValid[s] && slotIdx[s] == robIdxT'(i)) begin
          clearValid[i] = 1'b1;
        end
      end
      if (store.rollbackFire && (robIdxT'(i) - squashStart) < squashSpan) begin
        clearValid[i] = 1'b1;
      end
    end
    if (store.dispatchFire) begin
      writeEntry[store.tail]        = 1'b1;
      writeEntry[store.tailPlusOne] = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid    <= '0;
      complete <= '0;
    end else begin
      for (int i = 0; i < robDepth; i++) begin
        if (setComplete[i]) begin
          complete[i] <= 1'b1;
        end
        if (clearValid[i]) begin
          valid[i] <= 1'b0;
        end
        // dispatch targets free entries only
        if (writeEntry[i]) begin
          valid[i]    <= 1'b1;
          complete[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store.dispatchFire) begin
      halt[store.tail]        <= dispatchHalt[0];
      dest[store.tail]        <= dispatchDest[0];
      tag[store.tail]         <= dispatchTag[0];
      told[store.tail]        <= dispatchTold[0];
      halt[store.tailPlusOne] <= dispatchHalt[1];
      dest[store.tailPlusOne] <= dispatchDest[1];
      tag[store.tailPlusOne]  <= dispatchTag[1];
      told[store.tailPlusOne] <= dispatchTold[1];
    end
  end

endmodule

`default_nettype wire

// File: design/robPkg.sv
`default_nettype none

package robPkg;

  // buffer geometry
  localparam int robDepth = 16;
  localparam int superWidth = 2;

  // register file sizes
  localparam int archRegNum = 32;
  localparam int physRegNum = 64;

  // entry index and occupancy
  typedef logic [$clog2(robDepth)-1:0] robIdxT;
  typedef logic [$clog2(robDepth+1)-1:0] robCountT;

  // entries retired in one cycle, 0 to superWidth
  typedef logic [$clog2(superWidth+1)-1:0] retireCountT;

  // register tags
  typedef logic [$clog2(physRegNum)-1:0] physTagT;
  typedef logic [$clog2(archRegNum)-1:0] archRegT;

  // dispatch is blocked in recDrain until the buffer empties
  typedef enum logic {
    recNormal,
    recDrain
  } recoveryStateT;

endpackage

`default_nettype wire

// File: design/robPointers.sv
`timescale 1ns/1ps
`default_nettype none

module robPointers import robPkg::*; (
  input  wire logic clock,
  input  wire logic reset,
  robPtrIf.ptr      ptrs,
  output logic      freeTwo,
  output logic      empty
);

  robIdxT   head;
  robIdxT   tail;
  robCountT count;
  robIdxT   rollbackTail;
  robCountT keptCount;
  robCountT retired;

  assign retired = robCountT'(ptrs.retireCount);

  // tail lands just after the mispredicted branch
  assign rollbackTail = ptrs.rollbackIdx + robIdxT'(1);

  // distance head..new tail; zero means every entry is kept
  always_comb begin
    keptCount = {1'b0, rollbackTail - head};
    if (keptCount == '0) begin
      keptCount = robCountT'(robDepth);
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head <= head + robIdxT'(ptrs.retireCount);
      if (ptrs.rollbackFire) begin
        tail  <= rollbackTail;
        count <= keptCount - retired;
      end else if (ptrs.dispatchFire) begin
        tail  <= tail + robIdxT'(superWidth);
        count <= count + robCountT'(superWidth) - retired;
      end else begin
        count <= count - retired;
      end
    end
  end

  assign ptrs.head        = head;
  assign ptrs.tail        = tail;
  assign ptrs.headPlusOne = head + robIdxT'(1);
  assign ptrs.tailPlusOne = tail + robIdxT'(1);

  assign freeTwo = count <= robCountT'(robDepth - superWidth);
  assign empty   = count == '0;

endmodule

`default_nettype wire

// File: design/robPtrIf.sv
`timescale 1ns/1ps
`default_nettype none

interface robPtrIf import robPkg::*; ();

  // pointer state
  robIdxT      head;
  robIdxT      tail;
  robIdxT      headPlusOne;
  robIdxT      tailPlusOne;

  // events of the current cycle
  logic        dispatchFire;
  retireCountT retireCount;
  logic        rollbackFire;
  robIdxT      rollbackIdx;

  modport ptr (
    output head, tail, headPlusOne, tailPlusOne,
    input  dispatchFire, retireCount, rollbackFire, rollbackIdx
  );

  modport ctl (
    output dispatchFire, rollbackFire, rollbackIdx
  );

  modport store (
    input  head, tail, headPlusOne, tailPlusOne, dispatchFire, rollbackFire,
    output retireCount
  );

endinterface

`default_nettype wire

// File: design/robRecoveryFsm.sv
`timescale 1ns/1ps
`default_nettype none

module robRecoveryFsm import robPkg::*; (
  input  wire logic   clock,
  input  wire logic   reset,
  input  wire logic   dispatchEn,
  input  wire logic   rollbackEn,
  input  wire robIdxT rollbackIdx,
  input  wire logic   rollbackValid,
  input  wire logic   freeTwo,
  input  wire logic   empty,
  robPtrIf.ctl        ctl,
  output logic        robReady
);

  recoveryStateT state;

  // a pending rollback request also holds off dispatch
  assign robReady = (state == recNormal) && !rollbackEn && freeTwo;

  assign ctl.dispatchFire = dispatchEn && robReady;
  // requests naming an invalid entry are dropped
  assign ctl.rollbackFire = rollbackEn && rollbackValid;
  assign ctl.rollbackIdx  = rollbackIdx;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= recNormal;
    end else if (ctl.rollbackFire) begin
      state <= recDrain;
    end else if (state == recDrain && empty) begin
      state <= recNormal;
    end
  end

endmodule

`default_nettype wire

// File: robCore.f
design/robPkg.sv
design/robPtrIf.sv
design/robPointers.sv
design/robRecoveryFsm.sv
design/robEntryStore.sv
design/archMapTable.sv
design/reorderBuffer.sv
testbench/reorderBuffer_chk.sv
testbench/reorderBufferTb.sv

// File: testbench/reorderBufferTb.sv
`timescale 1ns/1ps
`default_nettype none

module reorderBufferTb import robPkg::*; ();

  logic                     clock;
  logic                     reset;
  logic                     dispatchEn;
  archRegT [superWidth-1:0] dispatchDest;
  physTagT [superWidth-1:0] dispatchTag;
  physTagT [superWidth-1:0] dispatchTold;
  logic    [superWidth-1:0] dispatchHalt;
  logic    [superWidth-1:0] completeEn;
  robIdxT  [superWidth-1:0] completeIdx;
  logic                     rollbackEn;
  robIdxT                   rollbackIdx;
  archRegT                  archReadReg;
  logic                     robReady;
  robIdxT  [superWidth-1:0] robIdx;
  logic    [superWidth-1:0] retireValid;
  physTagT [superWidth-1:0] retireTold;
  logic                     haltOut;
  physTagT                  archReadTag;

  // reference model, entries in program order
  typedef struct packed {
    robIdxT  idx;
    archRegT dest;
    physTagT tag;
    physTagT told;
    logic    halt;
    logic    done;
  } entryT;

  entryT       model[$];
  robIdxT      modelTail;
  logic        modelDrain;
  physTagT     modelMap [archRegNum];
  logic [31:0] rngState;
  int          haltCount;

  reorderBuffer i_reorderBuffer (
    .clock        (clock),
    .reset        (reset),
    .dispatchEn   (dispatchEn),
    .dispatchDest (dispatchDest),
    .dispatchTag  (dispatchTag),
    .dispatchTold (dispatchTold),
    .dispatchHalt (dispatchHalt),
    .completeEn   (completeEn),
    .completeIdx  (completeIdx),
    .rollbackEn   (rollbackEn),
    .rollbackIdx  (rollbackIdx),
    .archReadReg  (archReadReg),
    .robReady     (robReady),
    .robIdx       (robIdx),
    .retireValid  (retireValid),
    .retireTold   (retireTold),
    .haltOut      (haltOut),
    .archReadTag  (archReadTag)
  );

  bind reorderBuffer reorderBuffer_chk i_chk (
    .clock       (clock),
    .reset       (reset),
    .retireValid (retireValid),
    .robReady    (robReady),
    .haltOut     (haltOut),
    .state       (i_robRecoveryFsm.state),
    .count       (i_robPointers.count)
  );

  always #2 clock = ~clock;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got === expected)
      else reportFailure($sformatf("MISMATCH %s expected 0x%h got 0x%h", name, expected, got));
  endtask

  // one cycle of the model, compared before the next rising edge
  task automatic modelCycle();
    logic [1:0] expValid;
    logic       expReady;
    logic       expHalt;
    logic       rollbackHit;
    logic       drainEnds;
    entryT      fresh;
    expValid = '0;
    expHalt = 1'b0;
    rollbackHit = 1'b0;
    if (rollbackEn) begin
      foreach (model[k]) begin
        if (model[k].idx == rollbackIdx) begin
          rollbackHit = 1'b1;
        end
      end
    end
    if (model.size() > 0 && model[0].done) begin
      expValid[0] = 1'b1;
    end
    if (expValid[0] && model.size() > 1 && model[1].done) begin
      expValid[1] = 1'b1;
    end
    // a head branch that rolls back retires alone
    if (rollbackHit && model[0].idx == rollbackIdx) begin
      expValid[1] = 1'b0;
    end
    expReady = !modelDrain && !rollbackEn && model.size() <= robDepth - superWidth;
    checkValue("robReady", robReady, expReady);
    checkValue("robIdx[0]", robIdx[0], modelTail);
    checkValue("robIdx[1]", robIdx[1], robIdxT'(modelTail + 1));
    checkValue("retireValid", retireValid, expValid);
    for (int s = 0; s < superWidth; s++) begin
      if (expValid[s]) begin
        checkValue($sformatf("retireTold[%0d]", s), retireTold[s], model[s].told);
        expHalt = expHalt | model[s].halt;
      end
    end
    checkValue("haltOut", haltOut, expHalt);
    if (haltOut) begin
      haltCount++;
    end
    drainEnds = modelDrain && model.size() == 0;
    // slot 1 lands after slot 0 in the map
    for (int s = 0; s < superWidth; s++) begin
      if (expValid[s]) begin
        modelMap[model[0].dest] = model[0].tag;
        void'(model.pop_front());
      end
    end
    for (int s = 0; s < superWidth; s++) begin
      if (completeEn[s]) begin
        foreach (model[k]) begin
          if (model[k].idx == completeIdx[s]) begin
            model[k].done = 1'b1;
          end
        end
      end
    end
    if (dispatchEn && expReady) begin
      for (int s = 0; s < superWidth; s++) begin
        fresh.idx = robIdxT'(modelTail + s);
        fresh.dest = dispatchDest[s];
        fresh.tag = dispatchTag[s];
        fresh.told = dispatchTold[s];
        fresh.halt = dispatchHalt[s];
        fresh.done = 1'b0;
        model.push_back(fresh);
      end
      modelTail = robIdxT'(modelTail + superWidth);
    end
    if (rollbackHit) begin
      while (model.size() > 0 && model[$].idx != rollbackIdx) begin
        void'(model.pop_back());
      end
      modelTail = robIdxT'(rollbackIdx + 1);
      modelDrain = 1'b1;
    end else if (drainEnds) begin
      modelDrain = 1'b0;
    end
  endtask

  always @(negedge clock) begin
    if (!reset) begin
      modelCycle();
    end
  end

  // data held until the pair is accepted
  task automatic dispatchPair(input logic [4:0] destMask, input logic [1:0] halt);
    int waited;
    waited = 0;
    @(posedge clock);
    dispatchEn <= 1'b1;
    dispatchHalt <= halt;
    for (int s = 0; s < superWidth; s++) begin
      dispatchDest[s] <= archRegT'(nextRandom()) & destMask;
      dispatchTag[s] <= physTagT'(nextRandom());
      dispatchTold[s] <= physTagT'(nextRandom());
    end
    do begin
      @(negedge clock);
      waited++;
      assert (waited <= 100) else reportFailure("timeout waiting for robReady on dispatch");
    end while (!robReady);
    @(posedge clock);
    dispatchEn <= 1'b0;
  endtask

  task automatic completePair(input robIdxT idx0, input logic en0,
                              input robIdxT idx1, input logic en1);
    @(posedge clock);
    completeEn <= {en1, en0};
    completeIdx[0] <= idx0;
    completeIdx[1] <= idx1;
    @(posedge clock);
    completeEn <= '0;
  endtask

  task automatic completeInOrder();
    robIdxT pending[$];
    foreach (model[k]) begin
      pending.push_back(model[k].idx);
    end
    while (pending.size() > 1) begin
      completePair(pending[0], 1'b1, pending[1], 1'b1);
      void'(pending.pop_front());
      void'(pending.pop_front());
    end
    if (pending.size() == 1) begin
      completePair(pending[0], 1'b1, pending[0], 1'b0);
    end
  endtask

  task automatic waitReady();
    int waited;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
      assert (waited <= 200) else reportFailure("timeout waiting for robReady to rise");
    end while (!robReady);
  endtask

  task automatic waitDrained();
    int waited;
    waited = 0;
    while (model.size() != 0) begin
      @(posedge clock);
      waited++;
      assert (waited <= 200) else reportFailure("timeout waiting for the buffer to drain");
    end
  endtask

  task automatic readArchMap();
    for (int r = 0; r < archRegNum; r++) begin
      @(posedge clock);
      archReadReg <= archRegT'(r);
      @(negedge clock);
      checkValue($sformatf("archReadTag[%0d]", r), archReadTag, modelMap[r]);
    end
  endtask

  task automatic resetTest();
    @(negedge clock);
    checkValue("robReady", robReady, 1'b1);
    checkValue("robIdx[0]", robIdx[0], 0);
    checkValue("robIdx[1]", robIdx[1], 1);
    checkValue("retireValid", retireValid, 0);
    readArchMap();
  endtask

  task automatic outOfOrderTest();
    robIdxT order [8];
    robIdxT held;
    int     j;
    for (int p = 0; p < 4; p++) begin
      dispatchPair(5'h1f, 2'b00);
    end
    foreach (order[k]) begin
      order[k] = model[k].idx;
    end
    // shuffled completion order
    for (int k = 7; k > 0; k--) begin
      j = int'(nextRandom() % (k + 1));
      held = order[k];
      order[k] = order[j];
      order[j] = held;
    end
    for (int k = 0; k < 8; k += 2) begin
      completePair(order[k], 1'b1, order[k+1], 1'b1);
    end
    waitDrained();
  endtask

  task automatic fullBufferTest();
    robIdxT head0;
    robIdxT head1;
    for (int p = 0; p < robDepth / superWidth; p++) begin
      dispatchPair(5'h1f, 2'b00);
    end
    head0 = model[0].idx;
    head1 = model[1].idx;
    @(negedge clock);
    checkValue("robReady", robReady, 1'b0);
    completePair(head0, 1'b1, head1, 1'b1);
    waitReady();
    completeInOrder();
    waitDrained();
  endtask

  task automatic rollbackTest();
    robIdxT older [5];
    robIdxT branchIdx;
    robIdxT squashedIdx;
    for (int p = 0; p < 6; p++) begin
      dispatchPair(5'h1f, 2'b00);
    end
    foreach (older[k]) begin
      older[k] = model[k].idx;
    end
    branchIdx = model[4].idx;
    // first squashed entry, next at the head once the branch retires
    squashedIdx = model[5].idx;
    @(posedge clock);
    rollbackEn <= 1'b1;
    rollbackIdx <= branchIdx;
    @(posedge clock);
    rollbackEn <= 1'b0;
    completePair(squashedIdx, 1'b1, squashedIdx, 1'b0);
    completePair(older[0], 1'b1, older[1], 1'b1);
    completePair(older[2], 1'b1, older[3], 1'b1);
    // branch itself still incomplete
    @(negedge clock);
    checkValue("robReady", robReady, 1'b0);
    completePair(older[4], 1'b1, older[4], 1'b0);
    waitReady();
    checkValue("robIdx[0]", robIdx[0], robIdxT'(branchIdx + 1));
    checkValue("robIdx[1]", robIdx[1], robIdxT'(branchIdx + 2));
  endtask

  task automatic archMapHaltTest();
    int startHalts;
    startHalts = haltCount;
    // few dests so writers overlap
    dispatchPair(5'h03, 2'b00);
    dispatchPair(5'h03, 2'b10);
    dispatchPair(5'h03, 2'b00);
    completeInOrder();
    waitDrained();
    @(negedge clock);
    checkValue("haltCount", haltCount - startHalts, 1);
    readArchMap();
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    dispatchEn = 1'b0;
    dispatchDest = '0;
    dispatchTag = '0;
    dispatchTold = '0;
    dispatchHalt = '0;
    completeEn = '0;
    completeIdx = '0;
    rollbackEn = 1'b0;
    rollbackIdx = '0;
    archReadReg = '0;
    rngState = 32'hdbd5;
    modelTail = '0;
    modelDrain = 1'b0;
    haltCount = 0;
    for (int r = 0; r < archRegNum; r++) begin
      modelMap[r] = physTagT'(r);
    end
    repeat (16) @(posedge clock);
    reset <= 1'b0;
    resetTest();
    outOfOrderTest();
    fullBufferTest();
    rollbackTest();
    archMapHaltTest();
    if (i_reorderBuffer.i_chk.failCount == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      reportFailure("a concurrent assertion in the checker failed");
    end
  end

endmodule

`default_nettype wire

// File: testbench/reorderBuffer_chk.sv
`timescale 1ns/1ps
`default_nettype none

module reorderBuffer_chk import robPkg::*; (
  input wire logic                  clock,
  input wire logic                  reset,
  input wire logic [superWidth-1:0] retireValid,
  input wire logic                  robReady,
  input wire logic                  haltOut,
  input wire recoveryStateT         state,
  input wire robCountT              count
);

  // failed assertions so far
  int failCount = 0;

  // retirement is in order, slot 1 never alone
  assert property (@(posedge clock) disable iff (reset) retireValid[1] |-> retireValid[0])
    else begin
      $error("retire slot 1 active without slot 0");
      failCount++;
    end

  assert property (@(posedge clock) disable iff (reset) (state == recDrain) |-> !robReady)
    else begin
      $error("robReady high while draining after a rollback");
      failCount++;
    end

  assert property (@(posedge clock) disable iff (reset) haltOut |-> retireValid[0])
    else begin
      $error("haltOut high with no retiring entry");
      failCount++;
    end

  assert property (@(posedge clock) disable iff (reset) count <= robCountT'(robDepth))
    else begin
      $error("occupancy count above the buffer depth");
      failCount++;
    end

endmodule

`default_nettype wire
